// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcacheTb
RTL_TOP   ?= dcache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "$(RTL_TOP): failure reported in $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "$(RTL_TOP): run did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
verilog/cachePkg.sv
verilog/tagDirectory.sv
verilog/dataArray.sv
verilog/cacheController.sv
verilog/dcache.sv
testbench/dcache_sva.sv
testbench/dcacheTb.sv

// File: testbench/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;

    import cachePkg::*;

    localparam int clkPeriod   = 40;
    localparam int numRequests = 210;
    // Two waits of up to 6 cycles each plus the lookup, select, replay and update steps.
    localparam int worstCycles = 30;

    logic             clk = 1'b0;
    logic             resetn;
    logic             reqValid;
    logic [addrW-1:0] reqAddr;
    logic             reqWrite;
    logic [strbW-1:0] reqStrb;
    logic [dataW-1:0] reqWdata;
    logic [dataW-1:0] dataOut;
    logic             dataOutReady;
    logic             busy;
    logic [addrW-1:0] refillAddr;
    logic             refillValid;
    logic             refillReady = 1'b0;
    logic [lineW-1:0] refillData = '0;
    logic [addrW-1:0] writeBackAddr;
    logic [lineW-1:0] writeBackData;
    logic             writeBackValid;
    logic             writeBackAck = 1'b0;

    // Shadow of the control store and of the words by byte address.
    logic [tagW-1:0]  shTag   [numSets][numWays];
    logic [ageW-1:0]  shAge   [numSets][numWays];
    logic             shValid [numSets][numWays];
    logic             shDirty [numSets][numWays];
    logic [dataW-1:0] nextMem [logic [addrW-1:0]];
    logic [dataW-1:0] refMem  [logic [addrW-1:0]];
    logic [addrW-1:0] expRefillAddr;
    logic [addrW-1:0] expWbAddr;
    int               refillCount = 0;
    int               wbCount = 0;
    int               expRefills = 0;
    int               expWbs = 0;
    int               waitCnt = 0;

    dcache DUT (.*);

    always #(clkPeriod / 2) clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input string name, input logic [lineW-1:0] got,
                           input logic [lineW-1:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                              $time, name, got, exp));
        end
    endtask

    // Content of a word that was never written back.
    function automatic logic [dataW-1:0] fillWord(input logic [addrW-1:0] addr);
        return addr * 32'h9e37_79b1 ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [dataW-1:0] memWord(input logic [addrW-1:0] addr);
        return nextMem.exists(addr) ? nextMem[addr] : fillWord(addr);
    endfunction

    function automatic logic [dataW-1:0] refWord(input logic [addrW-1:0] addr);
        return refMem.exists(addr) ? refMem[addr] : memWord(addr);
    endfunction

    function automatic logic [lineW-1:0] lineOf(input logic [addrW-1:0] base, input bit fromRef);
        logic [lineW-1:0] line;
        for (int i = 0; i < wordsPerLine; i++) begin
            line[i*dataW +: dataW] = fromRef ? refWord(base + 4*i) : memWord(base + 4*i);
        end
        return line;
    endfunction

    function automatic int victimOf(input int set);
        int v;
        v = -1;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (!shValid[set][w]) v = w;
        end
        for (int w = 0; w < numWays && v < 0; w++) begin
            if (shAge[set][w] == 2'd3) v = w;
        end
        return v;
    endfunction

    function automatic void touchAge(input int set, input int way);
        logic [ageW-1:0] old;
        old = shAge[set][way];
        for (int w = 0; w < numWays; w++) begin
            if (shAge[set][w] < old) shAge[set][w] = shAge[set][w] + 1'b1;
        end
        shAge[set][way] = '0;
    endfunction

    // Next-level memory that serves each transfer after 0 to 5 idle cycles.
    always @(posedge clk) begin
        refillReady  <= 1'b0;
        writeBackAck <= 1'b0;
        if ((refillValid && !refillReady) || (writeBackValid && !writeBackAck)) begin
            if (waitCnt != 0) begin
                waitCnt <= waitCnt - 1;
            end else if (refillValid) begin
                checkEq("refillAddr", refillAddr, expRefillAddr);
                refillData  <= lineOf(refillAddr, 1'b0);
                refillReady <= 1'b1;
                refillCount++;
                waitCnt <= $urandom_range(5, 0);
            end else begin
                checkEq("writeBackAddr", writeBackAddr, expWbAddr);
                checkEq("writeBackData", writeBackData, lineOf(writeBackAddr, 1'b1));
                for (int i = 0; i < wordsPerLine; i++) begin
                    nextMem[writeBackAddr + 4*i] = writeBackData[i*dataW +: dataW];
                end
                writeBackAck <= 1'b1;
                wbCount++;
                waitCnt <= $urandom_range(5, 0);
            end
        end
    end

    always @(posedge clk) begin
        if (DUT.uSva.errorCount != 0) failRun("a protocol assertion failed");
    end

    // Predicts the response, then runs one request until busy falls.
    task automatic issueRequest(input logic [addrW-1:0] addr, input logic wr,
                                input logic [strbW-1:0] strb, input logic [dataW-1:0] wdata);
        int set;
        int way;
        logic [tagW-1:0]  tag;
        logic [dataW-1:0] oldWord;
        set = int'(addr[offsetW +: indexW]);
        tag = addr[addrW-1 -: tagW];
        way = -1;
        for (int w = 0; w < numWays; w++) begin
            if (shValid[set][w] && shTag[set][w] == tag) way = w;
        end
        if (way < 0) begin
            way = victimOf(set);
            expRefills++;
            expRefillAddr = {addr[addrW-1:offsetW], 5'b0};
            if (shValid[set][way] && shDirty[set][way]) begin
                expWbs++;
                expWbAddr = {shTag[set][way], addr[offsetW +: indexW], 5'b0};
            end
            shTag[set][way]   = tag;
            shValid[set][way] = 1'b1;
            shDirty[set][way] = 1'b0;
            touchAge(set, way);
        end
        touchAge(set, way);
        shDirty[set][way] = shDirty[set][way] | wr;
        oldWord = refWord(addr);
        reqValid <= 1'b1;
        reqAddr  <= addr;
        reqWrite <= wr;
        reqStrb  <= strb;
        reqWdata <= wdata;
        @(posedge clk);
        reqValid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!dataOutReady);
        checkEq("dataOut", dataOut, oldWord);
        checkEq("refill count", refillCount, expRefills);
        checkEq("write-back count", wbCount, expWbs);
        if (wr) begin
            for (int b = 0; b < strbW; b++) begin
                if (strb[b]) oldWord[b*8 +: 8] = wdata[b*8 +: 8];
            end
            refMem[addr] = oldWord;
        end
        do begin
            @(posedge clk);
        end while (busy);
    endtask

    initial begin
        void'($urandom(32'hcabb_ade3));
        resetn   = 1'b0;
        reqValid = 1'b0;
        reqAddr  = '0;
        reqWrite = 1'b0;
        reqStrb  = '0;
        reqWdata = '0;
        for (int s = 0; s < numSets; s++) begin
            for (int w = 0; w < numWays; w++) begin
                shTag[s][w]   = '0;
                shAge[s][w]   = ageW'(w);
                shValid[s][w] = 1'b0;
                shDirty[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            checkEq("busy", busy, 1'b0);
            checkEq("dataOutReady", dataOutReady, 1'b0);
            checkEq("refillValid", refillValid, 1'b0);
            checkEq("writeBackValid", writeBackValid, 1'b0);
        end
        // Miss, repeat hit, strobed write hit, read back.
        issueRequest(32'h0001_2344, 1'b0, '0, '0);
        issueRequest(32'h0001_2344, 1'b0, '0, '0);
        issueRequest(32'h0001_2344, 1'b1, strbW'($urandom), $urandom);
        issueRequest(32'h0001_2344, 1'b0, '0, '0);
        // Six tags in set 9 give a clean eviction and then write back the dirty way 1.
        for (int i = 0; i < 6; i++) begin
            issueRequest({tagW'(32'h300 + i), 7'd9, 5'd8}, i == 1, 4'hf, $urandom);
        end
        // The four predicted survivors must hit without a refill.
        for (int i = 2; i < 6; i++) begin
            issueRequest({tagW'(32'h300 + i), 7'd9, 5'd8}, 1'b0, '0, '0);
        end
        for (int i = 0; i < numRequests - 14; i++) begin
            issueRequest({tagW'(32'h100 + $urandom_range(5, 0)), indexW'($urandom_range(3, 0)),
                          wordSelW'($urandom), 2'b00}, 1'($urandom), strbW'($urandom), $urandom);
        end
        @(negedge clk);
        if (DUT.uSva.errorCount != 0) begin
            failRun("a protocol assertion failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    initial begin
        #(numRequests * worstCycles * clkPeriod + 10 * clkPeriod);
        failRun("timeout: the cache did not finish all requests in time");
    end

endmodule

`default_nettype wire

// File: testbench/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
    input wire logic                       clk,
    input wire logic                       resetn,
    input wire logic                       busy,
    input wire logic                       dataOutReady,
    input wire logic [cachePkg::addrW-1:0] refillAddr,
    input wire logic                       refillValid,
    input wire logic                       refillReady,
    input wire logic [cachePkg::addrW-1:0] writeBackAddr,
    input wire logic [cachePkg::lineW-1:0] writeBackData,
    input wire logic                       writeBackValid,
    input wire logic                       writeBackAck
);

    // Number of failed assertions so far.
    int errorCount = 0;

    refillHeld: assert property (@(posedge clk) disable iff (!resetn)
        refillValid && !refillReady |=> refillValid && $stable(refillAddr))
        else begin
            $error("refill request dropped or changed before refillReady");
            errorCount++;
        end

    writeBackHeld: assert property (@(posedge clk) disable iff (!resetn)
        writeBackValid && !writeBackAck |=>
            writeBackValid && $stable(writeBackAddr) && $stable(writeBackData))
        else begin
            $error("write-back dropped or changed before writeBackAck");
            errorCount++;
        end

    // One next-level transfer at a time.
    oneTransfer: assert property (@(posedge clk) disable iff (!resetn)
        !(refillValid && writeBackValid))
        else begin
            $error("refillValid and writeBackValid high together");
            errorCount++;
        end

    responseWhileBusy: assert property (@(posedge clk) disable iff (!resetn)
        dataOutReady |-> busy)
        else begin
            $error("dataOutReady high while busy is low");
            errorCount++;
        end

endmodule

bind dcache dcache_sva uSva (
    .clk(clk), .resetn(resetn), .busy(busy), .dataOutReady(dataOutReady),
    .refillAddr(refillAddr), .refillValid(refillValid), .refillReady(refillReady),
    .writeBackAddr(writeBackAddr), .writeBackData(writeBackData),
    .writeBackValid(writeBackValid), .writeBackAck(writeBackAck)
);

`default_nettype wire

// File: verilog/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController (
    input  wire logic                          clk,
    input  wire logic                          resetn,
    input  wire logic                          reqValid,
    input  wire logic [cachePkg::addrW-1:0]    reqAddr,
    input  wire logic                          reqWrite,
    input  wire logic [cachePkg::strbW-1:0]    reqStrb,
    input  wire logic [cachePkg::dataW-1:0]    reqWdata,
    input  wire logic                          hit,
    input  wire logic [cachePkg::wayIdxW-1:0]  hitWay,
    input  wire logic [cachePkg::wayIdxW-1:0]  victimWay,
    input  wire logic                          victimDirty,
    input  wire logic [cachePkg::tagW-1:0]     victimTag,
    input  wire logic [cachePkg::dataW-1:0]    rdWord,
    input  wire logic [cachePkg::lineW-1:0]    victimLine,
    input  wire logic                          refillReady,
    input  wire logic [cachePkg::lineW-1:0]    refillData,
    input  wire logic                          writeBackAck,
    output logic                               rdEn,
    output logic      [cachePkg::indexW-1:0]   index,
    output logic      [cachePkg::tagW-1:0]     lookupTag,
    output logic                               ctrlWrite,
    output logic                               allocate,
    output logic                               setDirty,
    output logic      [cachePkg::wordSelW-1:0] wordSel,
    output logic      [cachePkg::wayIdxW-1:0]  rdWay,
    output logic                               wrEn,
    output logic      [cachePkg::wayIdxW-1:0]  wrWay,
    output logic      [cachePkg::strbW-1:0]    wrStrb,
    output logic      [cachePkg::dataW-1:0]    wrData,
    output logic                               fillEn,
    output logic      [cachePkg::wayIdxW-1:0]  fillWay,
    output logic      [cachePkg::lineW-1:0]    fillData,
    output logic      [cachePkg::dataW-1:0]    dataOut,
    output logic                               dataOutReady,
    output logic                               busy,
    output logic      [cachePkg::addrW-1:0]    refillAddr,
    output logic                               refillValid,
    output logic      [cachePkg::addrW-1:0]    writeBackAddr,
    output logic      [cachePkg::lineW-1:0]    writeBackData,
    output logic                               writeBackValid
);

    import cachePkg::*;

    stateE               state;
    logic [tagW-1:0]     reqTagQ;
    logic [indexW-1:0]   reqIndexQ;
    logic [wordSelW-1:0] reqWordQ;
    logic                reqWriteQ;
    logic [strbW-1:0]    reqStrbQ;
    logic [dataW-1:0]    reqWdataQ;
    logic [wayIdxW-1:0]  fillWayQ;
    logic                accept;
    logic                refillDone;

    assign accept     = state == idle && reqValid;
    assign refillDone = state == refill && refillReady;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            case (state)
                idle:      if (reqValid) state <= lookup;
                lookup: begin
                    if (!hit) begin
                        state <= select;
                    end else if (reqWriteQ) begin
                        state <= update;
                    end else begin
                        state <= idle;
                    end
                end
                update:    state <= idle;
                select:    state <= victimDirty ? writeBack : refill;
                writeBack: if (writeBackAck) state <= refill;
                refill:    if (refillReady) state <= lookup;
                default:   state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqTagQ   <= reqAddr[offsetW + indexW +: tagW];
            reqIndexQ <= reqAddr[offsetW +: indexW];
            reqWordQ  <= reqAddr[offsetW - wordSelW +: wordSelW];
            reqWriteQ <= reqWrite;
            reqStrbQ  <= reqStrb;
            reqWdataQ <= reqWdata;
        end
        // Victim way, line and address are captured before the allocation lands.
        if (state == select) begin
            fillWayQ      <= victimWay;
            writeBackData <= victimLine;
            writeBackAddr <= {victimTag, reqIndexQ, {offsetW{1'b0}}};
        end
    end

    // Read on accept and again on the replay after a refill.
    assign rdEn      = accept || refillDone;
    assign index     = (state == idle) ? reqAddr[offsetW +: indexW] : reqIndexQ;
    assign lookupTag = reqTagQ;

    assign ctrlWrite = (state == lookup && hit && !reqWriteQ) || state == update ||
                       state == select;
    assign allocate  = state == select;
    assign setDirty  = state == update;

    assign wordSel   = reqWordQ;
    assign rdWay     = hitWay;
    assign wrEn      = state == update;
    assign wrWay     = hitWay;
    assign wrStrb    = reqStrbQ;
    assign wrData    = reqWdataQ;
    assign fillEn    = refillDone;
    assign fillWay   = fillWayQ;
    assign fillData  = refillData;

    assign dataOut        = rdWord;
    assign dataOutReady   = state == lookup && hit;
    assign busy           = state != idle;
    assign refillAddr     = {reqTagQ, reqIndexQ, {offsetW{1'b0}}};
    assign refillValid    = state == refill;
    assign writeBackValid = state == writeBack;

endmodule

`default_nettype wire

// File: verilog/cachePkg.sv
`default_nettype none

package cachePkg;

    // Cache geometry.
    localparam int numWays      = 4;
    localparam int wayIdxW      = 2;
    localparam int numSets      = 128;
    localparam int indexW       = 7;
    localparam int wordsPerLine = 8;
    localparam int wordSelW     = 3;
    localparam int offsetW      = 5;
    localparam int tagW         = 20;

    // Bus widths.
    localparam int addrW        = 32;
    localparam int dataW        = 32;
    localparam int lineW        = wordsPerLine * dataW;
    localparam int strbW        = dataW / 8;

    // One age counter per way, 0 is the most recently used.
    localparam int ageW         = 2;

    // Control entry of one way: dirty, valid, age, tag from the top down.
    localparam int wayEntryW    = 24;
    localparam int tagLsb       = 0;
    localparam int ageLsb       = 20;
    localparam int validBit     = 22;
    localparam int dirtyBit     = 23;

    // Controller states.
    typedef enum logic [2:0] {
        idle      = 3'd0,
        lookup    = 3'd1,
        update    = 3'd2,
        select    = 3'd3,
        writeBack = 3'd4,
        refill    = 3'd5
    } stateE;

    // Control word of one set.
    // The store moves it as one flat word, the lookup logic splits it by way.
    typedef union packed {
        logic [numWays*wayEntryW-1:0]      raw;
        logic [numWays-1:0][wayEntryW-1:0] way;
    } setCtrlU;

endpackage

`default_nettype wire

// File: verilog/dataArray.sv
`timescale 1ns/1ps
`default_nettype none

module dataArray (
    input  wire logic                          clk,
    input  wire logic                          rdEn,
    input  wire logic [cachePkg::indexW-1:0]   index,
    input  wire logic [cachePkg::wordSelW-1:0] wordSel,
    input  wire logic [cachePkg::wayIdxW-1:0]  rdWay,
    input  wire logic                          wrEn,
    input  wire logic [cachePkg::wayIdxW-1:0]  wrWay,
    input  wire logic [cachePkg::strbW-1:0]    wrStrb,
    input  wire logic [cachePkg::dataW-1:0]    wrData,
    input  wire logic                          fillEn,
    input  wire logic [cachePkg::wayIdxW-1:0]  fillWay,
    input  wire logic [cachePkg::lineW-1:0]    fillData,
    input  wire logic [cachePkg::wayIdxW-1:0]  victimWay,
    output logic      [cachePkg::dataW-1:0]    rdWord,
    output logic      [cachePkg::lineW-1:0]    victimLine
);

    import cachePkg::*;

    // Lines of the last set read, one per way.
    logic [lineW-1:0] lineQ [numWays];

    for (genvar w = 0; w < numWays; w++) begin : gWay
        logic [lineW-1:0] store [numSets];
        logic             fillHere;
        logic             writeHere;

        assign fillHere  = fillEn && fillWay == wayIdxW'(w);
        assign writeHere = wrEn && wrWay == wayIdxW'(w);

        always_ff @(posedge clk) begin
            if (fillHere) begin
                store[index] <= fillData;
            end else if (writeHere) begin
                for (int b = 0; b < strbW; b++) begin
                    if (wrStrb[b]) begin
                        store[index][wordSel*dataW + b*8 +: 8] <= wrData[b*8 +: 8];
                    end
                end
            end
        end

        // A refill and the replay read share an edge, so the new line is passed on.
        always_ff @(posedge clk) begin
            if (rdEn) begin
                lineQ[w] <= fillHere ? fillData : store[index];
            end
        end
    end

    assign rdWord     = lineQ[rdWay][wordSel*dataW +: dataW];
    assign victimLine = lineQ[victimWay];

endmodule

`default_nettype wire

// File: verilog/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire logic                       clk,
    input  wire logic                       resetn,
    input  wire logic                       reqValid,
    input  wire logic [cachePkg::addrW-1:0] reqAddr,
    input  wire logic                       reqWrite,
    input  wire logic [cachePkg::strbW-1:0] reqStrb,
    input  wire logic [cachePkg::dataW-1:0] reqWdata,
    output logic      [cachePkg::dataW-1:0] dataOut,
    output logic                            dataOutReady,
    output logic                            busy,
    output logic      [cachePkg::addrW-1:0] refillAddr,
    output logic                            refillValid,
    input  wire logic                       refillReady,
    input  wire logic [cachePkg::lineW-1:0] refillData,
    output logic      [cachePkg::addrW-1:0] writeBackAddr,
    output logic      [cachePkg::lineW-1:0] writeBackData,
    output logic                            writeBackValid,
    input  wire logic                       writeBackAck
);

    // Shared read strobe and index.
    logic                            rdEn;
    logic [cachePkg::indexW-1:0]     index;

    // Directory side.
    logic [cachePkg::tagW-1:0]       lookupTag;
    logic                            ctrlWrite;
    logic                            allocate;
    logic                            setDirty;
    logic                            hit;
    logic [cachePkg::wayIdxW-1:0]    hitWay;
    logic [cachePkg::wayIdxW-1:0]    victimWay;
    logic                            victimDirty;
    logic [cachePkg::tagW-1:0]       victimTag;

    // Array side.
    logic [cachePkg::wordSelW-1:0]   wordSel;
    logic [cachePkg::wayIdxW-1:0]    rdWay;
    logic                            wrEn;
    logic [cachePkg::wayIdxW-1:0]    wrWay;
    logic [cachePkg::strbW-1:0]      wrStrb;
    logic [cachePkg::dataW-1:0]      wrData;
    logic                            fillEn;
    logic [cachePkg::wayIdxW-1:0]    fillWay;
    logic [cachePkg::lineW-1:0]      fillData;
    logic [cachePkg::dataW-1:0]      rdWord;
    logic [cachePkg::lineW-1:0]      victimLine;

    tagDirectory uTagDirectory (
        .clk(clk), .resetn(resetn), .rdEn(rdEn), .rdIndex(index),
        .lookupTag(lookupTag), .ctrlWrite(ctrlWrite), .allocate(allocate),
        .setDirty(setDirty), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .victimDirty(victimDirty), .victimTag(victimTag)
    );

    dataArray uDataArray (
        .clk(clk), .rdEn(rdEn), .index(index), .wordSel(wordSel), .rdWay(rdWay),
        .wrEn(wrEn), .wrWay(wrWay), .wrStrb(wrStrb), .wrData(wrData),
        .fillEn(fillEn), .fillWay(fillWay), .fillData(fillData),
        .victimWay(victimWay), .rdWord(rdWord), .victimLine(victimLine)
    );

    cacheController uCacheController (
        .clk(clk), .resetn(resetn), .reqValid(reqValid), .reqAddr(reqAddr),
        .reqWrite(reqWrite), .reqStrb(reqStrb), .reqWdata(reqWdata),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimDirty(victimDirty),
        .victimTag(victimTag), .rdWord(rdWord), .victimLine(victimLine),
        .refillReady(refillReady), .refillData(refillData), .writeBackAck(writeBackAck),
        .rdEn(rdEn), .index(index), .lookupTag(lookupTag), .ctrlWrite(ctrlWrite),
        .allocate(allocate), .setDirty(setDirty), .wordSel(wordSel), .rdWay(rdWay),
        .wrEn(wrEn), .wrWay(wrWay), .wrStrb(wrStrb), .wrData(wrData),
        .fillEn(fillEn), .fillWay(fillWay), .fillData(fillData),
        .dataOut(dataOut), .dataOutReady(dataOutReady), .busy(busy),
        .refillAddr(refillAddr), .refillValid(refillValid),
        .writeBackAddr(writeBackAddr), .writeBackData(writeBackData),
        .writeBackValid(writeBackValid)
    );

endmodule

`default_nettype wire

// File: verilog/tagDirectory.sv
`timescale 1ns/1ps
`default_nettype none

module tagDirectory (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire logic                         rdEn,
    input  wire logic [cachePkg::indexW-1:0]  rdIndex,
    input  wire logic [cachePkg::tagW-1:0]    lookupTag,
    input  wire logic                         ctrlWrite,
    input  wire logic                         allocate,
    input  wire logic                         setDirty,
    output logic                              hit,
    output logic      [cachePkg::wayIdxW-1:0] hitWay,
    output logic      [cachePkg::wayIdxW-1:0] victimWay,
    output logic                              victimDirty,
    output logic      [cachePkg::tagW-1:0]    victimTag
);

    import cachePkg::*;

    setCtrlU             store [numSets];
    setCtrlU             rdWordQ;
    setCtrlU             nextWord;
    setCtrlU             resetWord;
    logic [indexW-1:0]   rdIndexQ;
    logic [wayIdxW-1:0]  touchWay;
    logic [ageW-1:0]     touchAge;

    // All ways invalid and clean, ages 0 to 3 in way order.
    always_comb begin
        resetWord.raw = '0;
        for (int w = 0; w < numWays; w++) begin
            resetWord.way[w][ageLsb +: ageW] = ageW'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < numSets; s++) begin
                store[s] <= resetWord;
            end
        end else if (ctrlWrite) begin
            store[rdIndexQ].raw <= nextWord.raw;
        end
    end

    // Registered read, the index is kept for the write back.
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdWordQ.raw <= store[rdIndex].raw;
            rdIndexQ    <= rdIndex;
        end
    end

    always_comb begin
        hit    = 1'b0;
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (rdWordQ.way[w][validBit] &&
                rdWordQ.way[w][tagLsb +: tagW] == lookupTag) begin
                hit    = 1'b1;
                hitWay = wayIdxW'(w);
            end
        end
    end

    // Oldest way first, then the lowest invalid way overrides it.
    always_comb begin
        victimWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (rdWordQ.way[w][ageLsb +: ageW] == {ageW{1'b1}}) begin
                victimWay = wayIdxW'(w);
            end
        end
        for (int w = numWays - 1; w >= 0; w--) begin
            if (!rdWordQ.way[w][validBit]) begin
                victimWay = wayIdxW'(w);
            end
        end
    end

    assign victimDirty = rdWordQ.way[victimWay][validBit] && rdWordQ.way[victimWay][dirtyBit];
    assign victimTag   = rdWordQ.way[victimWay][tagLsb +: tagW];

    // Age touch, plus allocation or dirty marking of the touched way.
    always_comb begin
        touchWay = allocate ? victimWay : hitWay;
        touchAge = rdWordQ.way[touchWay][ageLsb +: ageW];
        nextWord = rdWordQ;
        for (int w = 0; w < numWays; w++) begin
            if (wayIdxW'(w) == touchWay) begin
                nextWord.way[w][ageLsb +: ageW] = '0;
            end else if (rdWordQ.way[w][ageLsb +: ageW] < touchAge) begin
                nextWord.way[w][ageLsb +: ageW] = rdWordQ.way[w][ageLsb +: ageW] + 1'b1;
            end
        end
        if (allocate) begin
            nextWord.way[touchWay][tagLsb +: tagW] = lookupTag;
            nextWord.way[touchWay][validBit]       = 1'b1;
            nextWord.way[touchWay][dirtyBit]       = 1'b0;
        end
        if (setDirty) begin
            nextWord.way[touchWay][dirtyBit] = 1'b1;
        end
    end

endmodule

`default_nettype wire
